// ==== cd_frame_pkg.sv ====
// frame format constants, crc-16 parameters and the byte-wise crc update function
package cd_frame_pkg;

    localparam int HDR_LEN      = 3;    // src, dst, len
    localparam int MAX_DATA_LEN = 253;  // largest user length
    localparam int CRC_LEN      = 2;    // crc low byte, then high byte

    localparam logic [15:0] CRC_POLY    = 16'hA001;  // reflected 8005
    localparam logic [15:0] CRC_INIT    = 16'hFFFF;
    localparam logic [15:0] CRC_RESIDUE = 16'h0000;  // crc over an intact frame incl. its crc

    // fold one byte into the crc, lsb first
    function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] data);
        logic [15:0] c;
        c = crc ^ {8'h00, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage

// ==== cd_buf_pkg.sv ====
// receive buffer geometry defaults and index entry field widths
package cd_buf_pkg;

    localparam int DEF_I_WIDTH = 6;   // 64 index entries and 64 blocks
    localparam int DEF_B_WIDTH = 11;  // 2048 byte buffer

    localparam int BLOCK_BYTES = 2 ** (DEF_B_WIDTH - DEF_I_WIDTH);  // 32 bytes per block

    // index entry is {err, frag count, len}
    localparam int LEN_WIDTH = 8;  // user length field
    localparam int ERR_WIDTH = 1;  // error flag field

endpackage

// ==== cd_sdpram.sv ====
// simple dual-port ram with registered read, active-low enable and write enable
`timescale 1ns/1ps

module cd_sdpram #(
    parameter int A_WIDTH = 11,
    parameter int D_WIDTH = 8
) (
    input  logic               clk,
    input  logic               cen,  // active low, gates both ports
    input  logic [A_WIDTH-1:0] ra,
    output logic [D_WIDTH-1:0] rd,
    input  logic [A_WIDTH-1:0] wa,
    input  logic [D_WIDTH-1:0] wd,
    input  logic               wen   // active low
);

    logic [D_WIDTH-1:0] mem [2**A_WIDTH];

    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[wa] <= wd;
            end
            rd <= mem[ra];  // read-before-write on equal addresses
        end
    end

endmodule

// ==== cd_crc16.sv ====
// byte-wise crc-16 accumulator with clear and update strobes
`timescale 1ns/1ps

module cd_crc16 (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        clear,   // restart with the init value
    input  logic        update,  // fold data in
    input  logic [7:0]  data,
    output logic [15:0] crc
);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            crc <= cd_frame_pkg::CRC_INIT;
        end
        else if (clear) begin
            crc <= cd_frame_pkg::CRC_INIT;  // clear wins over update
        end
        else if (update) begin
            crc <= cd_frame_pkg::crc16_byte(crc, data);  // eight reflected shift steps
        end
    end

endmodule

// ==== cd_rx_framer.sv ====
// frame parser: byte counting, buffer writes, length and crc check at end of frame
`timescale 1ns/1ps

module cd_rx_framer (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    input  logic       rx_end,    // one cycle pulse after the last byte
    output logic [7:0] wr_byte,
    output logic [7:0] wr_addr,
    output logic       wr_en,
    output logic [7:0] wr_len,
    output logic       wr_err,
    output logic       switch     // commit pulse, wr_len and wr_err valid here
);

    localparam logic [8:0] HDR       = 9'(cd_frame_pkg::HDR_LEN);
    localparam logic [8:0] FULL_ADD  = 9'(cd_frame_pkg::HDR_LEN + cd_frame_pkg::CRC_LEN);
    localparam logic [8:0] MAX_STORE = 9'(cd_frame_pkg::MAX_DATA_LEN + cd_frame_pkg::HDR_LEN);

    logic [8:0]  byte_cnt;   // saturates, frames are at most 258 bytes
    logic [7:0]  data_len;   // n field of the current frame
    logic [15:0] crc;
    logic [8:0]  store_end;
    logic        store_ok;

    // header plus data, clamped so the address never wraps past 255
    assign store_end = (({1'b0, data_len} + HDR) > MAX_STORE) ? MAX_STORE
                                                              : ({1'b0, data_len} + HDR);
    assign store_ok  = (byte_cnt < HDR) || (byte_cnt < store_end);

    cd_crc16 crc_m (
        .clk     (clk),
        .reset_n (reset_n),
        .clear   (rx_end),
        .update  (rx_valid),
        .data    (rx_byte),
        .crc     (crc)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_cnt <= '0;
            wr_en    <= 1'b0;
            switch   <= 1'b0;
        end
        else begin
            wr_en  <= rx_valid & store_ok;     // crc bytes are not stored
            switch <= rx_end && (byte_cnt >= HDR);  // runts vanish silently
            if (rx_end) begin
                byte_cnt <= '0;
            end
            else if (rx_valid && (byte_cnt != '1)) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_byte <= rx_byte;
        wr_addr <= byte_cnt[7:0];
        if (rx_valid && (byte_cnt == HDR - 1'b1)) begin
            data_len <= rx_byte;  // length byte
        end
        if (rx_end) begin
            wr_len <= data_len;
            wr_err <= (byte_cnt != ({1'b0, data_len} + FULL_ADD))
                      || (crc != cd_frame_pkg::CRC_RESIDUE);
        end
    end

endmodule

// ==== cd_rx_ram.sv ====
// receive frame buffer: dirty-bit block ring, byte ram and frame index table
`timescale 1ns/1ps

module cd_rx_ram #(
    parameter int I_WIDTH = cd_buf_pkg::DEF_I_WIDTH,
    parameter int B_WIDTH = cd_buf_pkg::DEF_B_WIDTH
) (
    input  logic                             clk,
    input  logic                             reset_n,
    output logic [7:0]                       rd_byte,
    input  logic [7:0]                       rd_addr,
    input  logic                             rd_en,
    input  logic                             rd_done,      // free the oldest frame
    input  logic                             rd_done_all,  // flush everything
    output logic                             unread,
    output logic [cd_buf_pkg::LEN_WIDTH-1:0] rd_len,
    output logic                             rd_err,
    input  logic [7:0]                       wr_byte,
    input  logic [7:0]                       wr_addr,
    input  logic                             wr_en,
    input  logic                             wr_err,
    input  logic [cd_buf_pkg::LEN_WIDTH-1:0] wr_len,
    input  logic                             switch,
    output logic                             switch_fail
);

    localparam int S_WIDTH = B_WIDTH - I_WIDTH;  // block offset bits
    localparam int F_WIDTH = 8 - S_WIDTH;        // extra blocks a 256 byte frame can span
    localparam int L_WIDTH = cd_buf_pkg::LEN_WIDTH;
    localparam int E_WIDTH = cd_buf_pkg::ERR_WIDTH + F_WIDTH + L_WIDTH;

    logic [I_WIDTH-1:0]    wr_sel;      // first block of the frame being written
    logic [I_WIDTH-1:0]    rd_sel;      // first block of the oldest frame
    logic [I_WIDTH-1:0]    wr_blk;
    logic [2**I_WIDTH-1:0] dirty;       // set on a frame's first block only
    logic                  wr_cancel;
    logic                  wr_en_d;
    logic                  fail_pend;
    logic                  commit;
    logic [F_WIDTH-1:0]    wr_frag;     // blocks used minus one
    logic [F_WIDTH-1:0]    rd_frag;
    logic [7:0]            wr_byte_d;
    logic [B_WIDTH-1:0]    buf_wr_addr;
    logic [B_WIDTH-1:0]    buf_rd_addr;
    logic [E_WIDTH-1:0]    idx_rd_val;

    assign wr_blk      = wr_sel + I_WIDTH'(wr_addr[7:S_WIDTH]);
    assign commit      = switch & ~wr_cancel;
    assign buf_rd_addr = (B_WIDTH'(rd_sel) << S_WIDTH) + B_WIDTH'(rd_addr);  // wraps with the ring

    assign rd_len  = idx_rd_val[L_WIDTH-1:0];
    assign rd_frag = idx_rd_val[L_WIDTH +: F_WIDTH];
    assign rd_err  = idx_rd_val[E_WIDTH-1];

    cd_sdpram #(.A_WIDTH(B_WIDTH), .D_WIDTH(8)) buf_m (
        .clk (clk),
        .cen (~(rd_en | wr_en_d)),
        .ra  (buf_rd_addr),
        .rd  (rd_byte),
        .wa  (buf_wr_addr),
        .wd  (wr_byte_d),
        .wen (~wr_en_d)
    );

    // index read runs while the oldest frame is pending so rd_len tracks rd_sel
    cd_sdpram #(.A_WIDTH(I_WIDTH), .D_WIDTH(E_WIDTH)) idx_m (
        .clk (clk),
        .cen (~(dirty[rd_sel] | commit)),
        .ra  (rd_sel),
        .rd  (idx_rd_val),
        .wa  (wr_sel),
        .wd  ({wr_err, wr_frag, wr_len}),
        .wen (~commit)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_sel      <= '0;
            rd_sel      <= '0;
            dirty       <= '0;
            wr_cancel   <= 1'b0;
            wr_en_d     <= 1'b0;
            wr_frag     <= '0;
            fail_pend   <= 1'b0;
            switch_fail <= 1'b0;
            unread      <= 1'b0;
        end
        else begin
            wr_en_d     <= 1'b0;
            fail_pend   <= switch & wr_cancel;
            switch_fail <= fail_pend;  // one extra stage, two cycles after switch
            unread      <= dirty[rd_sel];

            if (commit) begin
                dirty[wr_sel] <= 1'b1;
                wr_sel        <= wr_sel + I_WIDTH'(wr_frag) + 1'b1;  // may land on rd_sel
            end
            if (switch) begin
                wr_cancel <= 1'b0;
            end

            // byte 0 starts a fresh frame, dropping a cancel left by a discarded runt
            if (wr_en && (!wr_cancel || (wr_addr == 8'd0))) begin
                if (dirty[wr_blk]) begin
                    wr_cancel <= 1'b1;  // would overwrite an unread frame
                end
                else begin
                    wr_cancel <= 1'b0;
                    wr_en_d   <= 1'b1;
                    wr_frag   <= wr_addr[7:S_WIDTH];
                end
            end

            if (rd_done && dirty[rd_sel]) begin
                dirty[rd_sel] <= 1'b0;
                rd_sel        <= rd_sel + I_WIDTH'(rd_frag) + 1'b1;
            end

            if (rd_done_all) begin
                wr_sel      <= '0;
                rd_sel      <= '0;
                dirty       <= '0;
                wr_cancel   <= 1'b0;
                fail_pend   <= 1'b0;
                switch_fail <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_byte_d   <= wr_byte;
        buf_wr_addr <= (B_WIDTH'(wr_sel) << S_WIDTH) + B_WIDTH'(wr_addr);
    end

endmodule

// ==== cd_rx_top.sv ====
// receive path top level: frame parser feeding the block-ring frame buffer
`timescale 1ns/1ps

module cd_rx_top #(
    parameter int I_WIDTH = cd_buf_pkg::DEF_I_WIDTH,  // index entries and blocks
    parameter int B_WIDTH = cd_buf_pkg::DEF_B_WIDTH   // buffer bytes
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic [7:0]                       rx_byte,
    input  logic                             rx_valid,
    input  logic                             rx_end,
    input  logic [7:0]                       rd_addr,
    input  logic                             rd_en,
    input  logic                             rd_done,
    input  logic                             rd_done_all,
    output logic [7:0]                       rd_byte,
    output logic                             unread,
    output logic [cd_buf_pkg::LEN_WIDTH-1:0] rd_len,
    output logic                             rd_err,
    output logic                             switch_fail
);

    logic [7:0] wr_byte;
    logic [7:0] wr_addr;
    logic       wr_en;
    logic [7:0] wr_len;
    logic       wr_err;
    logic       switch;

    cd_rx_framer framer_m (
        .clk      (clk),
        .reset_n  (reset_n),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .rx_end   (rx_end),
        .wr_byte  (wr_byte),
        .wr_addr  (wr_addr),
        .wr_en    (wr_en),
        .wr_len   (wr_len),
        .wr_err   (wr_err),
        .switch   (switch)
    );

    cd_rx_ram #(.I_WIDTH(I_WIDTH), .B_WIDTH(B_WIDTH)) ram_m (
        .clk         (clk),
        .reset_n     (reset_n),
        .rd_byte     (rd_byte),
        .rd_addr     (rd_addr),
        .rd_en       (rd_en),
        .rd_done     (rd_done),
        .rd_done_all (rd_done_all),
        .unread      (unread),
        .rd_len      (rd_len),
        .rd_err      (rd_err),
        .wr_byte     (wr_byte),
        .wr_addr     (wr_addr),
        .wr_en       (wr_en),
        .wr_err      (wr_err),
        .wr_len      (wr_len),
        .switch      (switch),
        .switch_fail (switch_fail)
    );

endmodule

// ==== tb_clk_gen.sv ====
// testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 5,   // ns, 10 ns period
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;  // released on a rising edge
    end

endmodule

// ==== cd_rx_chk.sv ====
// concurrent assertions on the receive top level outputs and their bind into cd_rx_top
`timescale 1ns/1ps

module cd_rx_chk (
    input logic                             clk,
    input logic                             reset_n,
    input logic                             rd_done_all,
    input logic                             unread,
    input logic [cd_buf_pkg::LEN_WIDTH-1:0] rd_len,
    input logic                             rd_err,
    input logic                             switch_fail
);

    int assert_fails;  // failed assertion count

    // quiet in reset and on the first cycle out of it
    reset_quiet: assert property (@(posedge clk)
        !reset_n |-> (!unread && !switch_fail) ##1 (!unread && !switch_fail))
        else begin
            $error("unread or switch_fail active around reset");
            assert_fails++;
        end

    fail_single: assert property (@(posedge clk) disable iff (!reset_n)
        switch_fail |=> !switch_fail)
        else begin
            $error("switch_fail high for two cycles");
            assert_fails++;
        end

    flush_clears: assert property (@(posedge clk) disable iff (!reset_n)
        rd_done_all |-> ##2 !unread)
        else begin
            $error("unread still high two cycles after rd_done_all");
            assert_fails++;
        end

    err_len_range: assert property (@(posedge clk) disable iff (!reset_n)
        unread |-> !(rd_err && (rd_len > cd_frame_pkg::MAX_DATA_LEN)))
        else begin
            $error("rd_err set on a frame with rd_len above the maximum");
            assert_fails++;
        end

endmodule

bind cd_rx_top cd_rx_chk chk_m (.*);

// ==== tb_cd_rx.sv ====
// testbench top: frame builder with crc, stimulus, read-back checks, timeouts and verdict
`timescale 1ns/1ps

module tb_cd_rx;

    localparam int QDEPTH  = 128;  // expected frame queue, deeper than the ring
    localparam int TIMEOUT = 200;  // cycles per wait

    logic       clk;
    logic       reset_n;
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       rx_end;
    logic [7:0] rd_addr;
    logic       rd_en;
    logic       rd_done;
    logic       rd_done_all;
    logic [7:0] rd_byte;
    logic       unread;
    logic [cd_buf_pkg::LEN_WIDTH-1:0] rd_len;
    logic       rd_err;
    logic       switch_fail;

    integer     seed = 32999;
    int         errors;
    int         fail_pulses;
    int         head;
    int         tail;
    int         used;   // ring blocks held by pending frames
    int         n;
    logic [7:0] frm [0:257];  // frame on the wire
    logic [7:0] exp_data [0:QDEPTH-1][0:255];
    int         exp_len [0:QDEPTH-1];
    logic       exp_err [0:QDEPTH-1];

    tb_clk_gen #(.HALF_PERIOD(5), .RESET_CYCLES(16)) clk_m (.clk(clk), .reset_n(reset_n));

    cd_rx_top dut (.*);

    always @(negedge clk) begin
        if (reset_n && switch_fail) begin
            fail_pulses++;
        end
    end

    task automatic expect_eq(input logic [31:0] got, input logic [31:0] want, input string what);
        assert (got === want) else begin
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, what, got, want);
            errors++;
        end
    endtask

    // reflected crc-16 over the first count bytes of frm
    function automatic logic [15:0] calc_crc(input int count);
        logic [15:0] c;
        logic        lsb;
        c = cd_frame_pkg::CRC_INIT;
        for (int i = 0; i < count; i++) begin
            c = c ^ {8'h00, frm[i]};
            for (int b = 0; b < 8; b++) begin
                lsb = c[0];
                c   = c >> 1;
                if (lsb) begin
                    c = c ^ cd_frame_pkg::CRC_POLY;
                end
            end
        end
        return c;
    endfunction

    function automatic int blocks_for(input int len);
        return (len + cd_frame_pkg::HDR_LEN + cd_buf_pkg::BLOCK_BYTES - 1)
               / cd_buf_pkg::BLOCK_BYTES;
    endfunction

    // mode 0 good, 1 bad crc byte, 2 last data byte missing
    task automatic send_frame(input int len, input int mode, input bit keep);
        logic [15:0] crc;
        frm[0] = 8'($random(seed));
        frm[1] = 8'($random(seed));
        frm[2] = 8'(len);
        for (int i = 0; i < len; i++) begin
            frm[3 + i] = 8'($random(seed));
        end
        crc          = calc_crc(len + cd_frame_pkg::HDR_LEN);
        frm[len + 3] = (mode == 1) ? ~crc[7:0] : crc[7:0];  // low byte first
        frm[len + 4] = crc[15:8];
        if (keep) begin
            for (int i = 0; i < len + 3; i++) begin
                exp_data[tail][i] = frm[i];
            end
            exp_len[tail] = len;
            exp_err[tail] = (mode != 0);
            tail          = (tail + 1) % QDEPTH;
        end
        for (int i = 0; i < len + 5; i++) begin
            if (!(mode == 2 && i == len + 2)) begin
                @(posedge clk);
                rx_byte  <= frm[i];
                rx_valid <= 1'b1;
            end
        end
        @(posedge clk);
        rx_valid <= 1'b0;
        rx_end   <= 1'b1;
        @(posedge clk);
        rx_end <= 1'b0;
        repeat (4) @(posedge clk);  // commit settles before the next frame
    endtask

    task automatic wait_unread(input logic level);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (unread !== level && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (unread !== level) begin
            $display("timeout: unread did not go to %0b within %0d cycles", level, TIMEOUT);
            errors++;
        end
    endtask

    task automatic wait_fail_pulse(input int count);
        int cnt;
        cnt = 0;
        while (fail_pulses < count && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (fail_pulses < count) begin
            $display("timeout: switch_fail did not pulse for a frame that cannot fit");
            errors++;
        end
    endtask

    // check the oldest pending frame against the queue, then free it
    task automatic check_oldest();
        int len;
        wait_unread(1'b1);
        len = exp_len[head];
        expect_eq(rd_len, len, "rd_len");
        expect_eq(rd_err, exp_err[head], "rd_err");
        if (!exp_err[head]) begin
            for (int i = 0; i < len + 3; i++) begin
                @(posedge clk);
                rd_addr <= 8'(i);
                rd_en   <= 1'b1;
                @(posedge clk);
                rd_en <= 1'b0;
                @(negedge clk);
                expect_eq(rd_byte, exp_data[head][i], "rd_byte");
            end
        end
        @(posedge clk);
        rd_done <= 1'b1;
        @(posedge clk);
        rd_done <= 1'b0;
        @(posedge clk);  // index and unread follow one cycle later
        head = (head + 1) % QDEPTH;
    endtask

    initial begin
        rx_byte     = '0;
        rx_valid    = 1'b0;
        rx_end      = 1'b0;
        rd_addr     = '0;
        rd_en       = 1'b0;
        rd_done     = 1'b0;
        rd_done_all = 1'b0;
        for (int cnt = 0; cnt < 100 && reset_n !== 1'b1; cnt++) begin
            @(posedge clk);
        end
        if (reset_n !== 1'b1) begin
            $display("timeout: reset was never released");
            errors++;
        end
        repeat (2) @(posedge clk);

        send_frame(40, 0, 1'b1);
        check_oldest();
        wait_unread(1'b0);

        send_frame(12, 1, 1'b1);
        send_frame(9, 2, 1'b1);
        repeat (2) check_oldest();

        send_frame(0, 0, 1'b1);
        send_frame(cd_frame_pkg::MAX_DATA_LEN, 0, 1'b1);
        send_frame(77, 0, 1'b1);
        repeat (3) check_oldest();
        wait_unread(1'b0);

        // fill an empty ring until the next frame would reach a dirty block
        used = 0;
        for (int k = 0; k < QDEPTH; k++) begin
            n = $unsigned($random(seed)) % (cd_frame_pkg::MAX_DATA_LEN + 1);
            if (used + blocks_for(n) > 2 ** cd_buf_pkg::DEF_I_WIDTH) begin
                send_frame(n, 0, 1'b0);
                wait_fail_pulse(1);
                break;
            end
            send_frame(n, 0, 1'b1);
            used += blocks_for(n);
        end
        while (head != tail) begin
            check_oldest();
        end
        wait_unread(1'b0);

        send_frame(30, 0, 1'b1);
        send_frame(50, 0, 1'b1);
        wait_unread(1'b1);
        @(posedge clk);
        rd_done_all <= 1'b1;
        @(posedge clk);
        rd_done_all <= 1'b0;
        @(posedge clk);
        wait_unread(1'b0);
        head = tail;  // flushed frames are gone
        send_frame(25, 0, 1'b1);
        check_oldest();
        wait_unread(1'b0);

        expect_eq(fail_pulses, 1, "switch_fail pulse count");
        $display("checks failed: %0d, assertions failed: %0d", errors, dut.chk_m.assert_fails);
        if (errors == 0 && dut.chk_m.assert_fails == 0) begin
            $display("*** PASSED ***");
        end
        else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
cd_frame_pkg.sv
cd_buf_pkg.sv
cd_sdpram.sv
cd_crc16.sv
cd_rx_framer.sv
cd_rx_ram.sv
cd_rx_top.sv
tb_clk_gen.sv
cd_rx_chk.sv
tb_cd_rx.sv
